// File: Makefile
VERILATOR ?= verilator
TOP       := bch_decoder_tb
FILELIST  := bch_decoder.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
LINTFLAGS := --lint-only --timing -Wall --top-module $(TOP)
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bch_decoder.f
hdl/bch_pkg.sv
hdl/bch_syndrome.sv
hdl/bch_berlekamp.sv
hdl/bch_chien.sv
hdl/bch_apb_regs.sv
hdl/bch_decoder.sv
tb/bch_decoder_props.sv
tb/bch_decoder_tb.sv

// File: hdl/bch_apb_regs.sv
`timescale 1ns/1ns

module bch_apb_regs (
  input  logic        iclk,
  input  logic        ireset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        enable,
  input  logic        syn_busy,
  input  logic        ber_busy,
  input  logic        out_val,
  input  logic        out_decfail,
  input  logic [1:0]  out_nerr
);

  bch_pkg::reg_addr_t addr;
  logic [15:0]        corr_cnt;
  logic [15:0]        fail_cnt;
  logic [31:0]        rd_mux;
  logic               wr_en;
  logic               rd_en;
  logic               clr;
  logic               busy;

  // zero wait states
  assign pready = 1'b1;
  assign addr   = bch_pkg::reg_addr_t'(paddr);
  // writes land at the end of the access phase
  assign wr_en  = psel && penable && pwrite;
  // reads sample in the setup phase
  assign rd_en  = psel && !penable && !pwrite;
  assign clr    = wr_en && (addr == bch_pkg::addr_ctrl) && pwdata[1];
  // anything in the pipe, output stage included
  assign busy   = syn_busy || ber_busy || out_val;

  // -------------------------------------------------------------------------
  // read mux
  // -------------------------------------------------------------------------

  always_comb begin
    case (addr)
      bch_pkg::addr_ctrl:     rd_mux = {31'b0, enable};
      bch_pkg::addr_status:   rd_mux = {31'b0, busy};
      bch_pkg::addr_corr_cnt: rd_mux = {16'b0, corr_cnt};
      bch_pkg::addr_fail_cnt: rd_mux = {16'b0, fail_cnt};
      default:                rd_mux = '0;
    endcase
  end

  // -------------------------------------------------------------------------
  // registers and event counters
  // -------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      enable   <= 1'b0;
      corr_cnt <= '0;
      fail_cnt <= '0;
      prdata   <= '0;
    end else begin
      if (wr_en && (addr == bch_pkg::addr_ctrl)) begin
        enable <= pwdata[0];
      end
      // clear beats a same-cycle event
      if (clr) begin
        corr_cnt <= '0;
        fail_cnt <= '0;
      end else if (out_val) begin
        if (out_decfail) begin
          fail_cnt <= fail_cnt + 1'b1;
        end else if (out_nerr != 2'd0) begin
          corr_cnt <= corr_cnt + 1'b1;
        end
      end
      if (rd_en) begin
        prdata <= rd_mux;
      end
    end
  end

endmodule

// File: hdl/bch_berlekamp.sv
`timescale 1ns/1ns

module bch_berlekamp (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           syn_val,
  input  bch_pkg::data_t syn [1:bch_pkg::t2],
  input  bch_pkg::word_t syn_word,
  input  bch_pkg::ptr_t  syn_ptr,
  output logic           syn_rdy,
  output logic           loc_val,
  output bch_pkg::data_t loc_poly [0:bch_pkg::t],
  output bch_pkg::word_t loc_word,
  output bch_pkg::ptr_t  loc_ptr,
  output logic           busy
);

  bch_pkg::ber_state_t state;
  bch_pkg::data_t      gamma [0:bch_pkg::t2];
  bch_pkg::data_t      tetta [0:bch_pkg::t2];
  logic [bch_pkg::t2:0] tclr;
  bch_pkg::data_t      sigma;
  bch_pkg::data_t      kv;
  bch_pkg::rnd_cnt_t   cnt;
  bch_pkg::step_cnt_t  tcnt;
  logic                cnt_done;
  logic                tcnt_done;
  logic                tcnt_mask;
  logic                take;
  logic                swap;

  // idle while the previous locator is on the output
  assign syn_rdy = (state == bch_pkg::ber_wait) && !loc_val;
  assign take    = syn_val && syn_rdy;
  assign busy    = (state == bch_pkg::ber_step) || loc_val;
  // discrepancy nonzero and k not negative
  assign swap    = (gamma[0] != '0) && !kv[bch_pkg::m-1];

  // -------------------------------------------------------------------------
  // fsm, t rounds of t2+1 steps
  // -------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state   <= bch_pkg::ber_wait;
      loc_val <= 1'b0;
    end else begin
      loc_val <= (state == bch_pkg::ber_step) && cnt_done && tcnt_done;
      case (state)
        bch_pkg::ber_wait: if (take) state <= bch_pkg::ber_step;
        bch_pkg::ber_step: if (cnt_done && tcnt_done) state <= bch_pkg::ber_wait;
        default:           state <= bch_pkg::ber_wait;
      endcase
    end
  end

  // -------------------------------------------------------------------------
  // reformulated inversionless recursion, two multipliers
  // -------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (take) begin
      loc_word  <= syn_word;
      loc_ptr   <= syn_ptr;
      cnt       <= bch_pkg::rnd_cnt_t'(bch_pkg::t);
      cnt_done  <= (bch_pkg::t < 2);
      tcnt      <= bch_pkg::step_cnt_t'(bch_pkg::t2);
      tcnt_done <= 1'b0;
      tcnt_mask <= 1'b0;
      // even syndromes into gamma, odd ones into tetta, unit at t2
      for (int i = 0; i <= bch_pkg::t2; i++) begin
        gamma[i] <= ((i < bch_pkg::t2-1) && !i[0]) ? syn[i+1] :
                    ((i == bch_pkg::t2) ? bch_pkg::data_t'(1) : '0);
        tetta[i] <= ((i < bch_pkg::t2-1) && i[0]) ? syn[i+1] :
                    ((i == bch_pkg::t2) ? bch_pkg::data_t'(1) : '0);
        tclr[i]  <= (i == bch_pkg::t2-4) || (i == bch_pkg::t2-3);
      end
      sigma <= bch_pkg::data_t'(1);
      kv    <= '0;
    end else if (state == bch_pkg::ber_step) begin
      tcnt      <= tcnt - 1'b1;
      tcnt_done <= (tcnt == bch_pkg::step_cnt_t'(1));
      tcnt_mask <= (tcnt == bch_pkg::step_cnt_t'(1)) || (tcnt == bch_pkg::step_cnt_t'(2));
      if (tcnt_done) begin
        tcnt     <= bch_pkg::step_cnt_t'(bch_pkg::t2);
        cnt      <= cnt - 1'b1;
        cnt_done <= (cnt == bch_pkg::rnd_cnt_t'(2));
      end
      // new gamma term enters at the top
      gamma[bch_pkg::t2] <= (tcnt_mask ? '0 : bch_pkg::gf_mult(sigma, gamma[2])) ^
                            bch_pkg::gf_mult(gamma[0], tetta[1]);
      if (swap) begin
        tetta[bch_pkg::t2] <= tclr[0] ? '0 : (gamma[1] & {bch_pkg::m{~tcnt_done}});
      end else begin
        tetta[bch_pkg::t2] <= tclr[0] ? '0 : tetta[0];
      end
      for (int i = 1; i < bch_pkg::t2; i++) begin
        gamma[i] <= gamma[i+1];
      end
      for (int i = 0; i < bch_pkg::t2; i++) begin
        tetta[i] <= tetta[i+1];
      end
      // clear mask rotates, and skips two more at round end
      if (tcnt_done) begin
        tclr <= {tclr[0], 2'b00, tclr[bch_pkg::t2:3]};
      end else begin
        tclr <= {tclr[0], tclr[bch_pkg::t2:1]};
      end
      // end of round decision
      if (tcnt_done) begin
        gamma[0] <= gamma[1];
        if (swap) begin
          sigma <= gamma[0];
          kv    <= -kv;
        end else begin
          kv    <= kv + bch_pkg::data_t'(2);
        end
      end
    end
  end

  // locator sits in the low gamma cells
  always_comb begin
    for (int i = 0; i <= bch_pkg::t; i++) begin
      loc_poly[i] = gamma[i];
    end
  end

endmodule

// File: hdl/bch_chien.sv
`timescale 1ns/1ns

module bch_chien (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           loc_val,
  input  bch_pkg::data_t loc_poly [0:bch_pkg::t],
  input  bch_pkg::word_t loc_word,
  input  bch_pkg::ptr_t  loc_ptr,
  output logic           out_val,
  output bch_pkg::word_t out_word,
  output bch_pkg::ptr_t  out_ptr,
  output logic           out_decfail,
  output logic [1:0]     out_nerr
);

  bch_pkg::word_t     roots;
  bch_pkg::root_cnt_t root_cnt;
  logic [1:0]         deg;
  logic               fail;

  // -------------------------------------------------------------------------
  // lambda(alpha^-i) for every position at once
  // -------------------------------------------------------------------------

  always_comb begin
    bch_pkg::data_t acc;
    roots    = '0;
    root_cnt = '0;
    deg      = '0;
    for (int i = 0; i < bch_pkg::n; i++) begin
      acc = '0;
      for (int j = 0; j <= bch_pkg::t; j++) begin
        // alpha^(-i*j) written as a positive power
        acc = acc ^ bch_pkg::gf_mult(loc_poly[j], bch_pkg::gf_pow((bch_pkg::n - i) * j));
      end
      roots[i] = (acc == '0);
      root_cnt = root_cnt + bch_pkg::root_cnt_t'(roots[i]);
    end
    // degree from highest nonzero coefficient
    for (int j = 1; j <= bch_pkg::t; j++) begin
      if (loc_poly[j] != '0) begin
        deg = j[1:0];
      end
    end
  end

  // too many errors: root count and degree disagree
  assign fail = (root_cnt != bch_pkg::root_cnt_t'(deg));

  // -------------------------------------------------------------------------
  // output register
  // -------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      out_val <= 1'b0;
    end else begin
      out_val <= loc_val;
    end
  end

  always_ff @(posedge iclk) begin
    if (loc_val) begin
      // on failure the received word goes out untouched
      out_word    <= fail ? loc_word : (loc_word ^ roots);
      out_ptr     <= loc_ptr;
      out_decfail <= fail;
      out_nerr    <= deg;
    end
  end

endmodule

// File: hdl/bch_decoder.sv
`timescale 1ns/1ns

module bch_decoder (
  input  logic           iclk,
  input  logic           ireset,
  // word in
  input  logic           in_val,
  input  bch_pkg::word_t in_word,
  input  bch_pkg::ptr_t  in_ptr,
  output logic           in_rdy,
  // result pulse
  output logic           out_val,
  output bch_pkg::word_t out_word,
  output bch_pkg::ptr_t  out_ptr,
  output logic           out_decfail,
  output logic [1:0]     out_nerr,
  // apb, clocked by iclk
  input  logic           psel,
  input  logic           penable,
  input  logic           pwrite,
  input  logic [3:0]     paddr,
  input  logic [31:0]    pwdata,
  output logic [31:0]    prdata,
  output logic           pready
);

  logic           enable;
  logic           syn_busy;
  logic           ber_busy;
  // syndrome to berlekamp
  logic           syn_val;
  logic           syn_rdy;
  bch_pkg::data_t syn [1:bch_pkg::t2];
  bch_pkg::word_t syn_word;
  bch_pkg::ptr_t  syn_ptr;
  // berlekamp to chien
  logic           loc_val;
  bch_pkg::data_t loc_poly [0:bch_pkg::t];
  bch_pkg::word_t loc_word;
  bch_pkg::ptr_t  loc_ptr;

  bch_apb_regs bch_apb_regs_i (.*);

  bch_syndrome bch_syndrome_i (.busy(syn_busy), .*);

  bch_berlekamp bch_berlekamp_i (.busy(ber_busy), .*);

  bch_chien bch_chien_i (.*);

endmodule

// File: hdl/bch_pkg.sv
package bch_pkg;

  // -------------------------------------------------------------------------
  // code geometry, binary (15,5) bch, designed distance 7
  // -------------------------------------------------------------------------

  localparam int m      = 4;
  localparam int n      = 15;
  localparam int t      = 3;
  localparam int t2     = 2 * t;
  localparam int k      = 5;
  // x^4 + x + 1
  localparam int irrpol = 19;

  typedef logic [m-1:0] data_t;
  typedef logic [3:0]   ptr_t;
  typedef logic [n-1:0] word_t;

  // round, step and root counters
  typedef logic [$clog2(t+1)-1:0]  rnd_cnt_t;
  typedef logic [$clog2(t2+1)-1:0] step_cnt_t;
  typedef logic [$clog2(n+1)-1:0]  root_cnt_t;

  typedef enum logic {
    ber_wait,
    ber_step
  } ber_state_t;

  // apb word offsets
  typedef enum logic [3:0] {
    addr_ctrl     = 4'h0,
    addr_status   = 4'h4,
    addr_corr_cnt = 4'h8,
    addr_fail_cnt = 4'hC
  } reg_addr_t;

  // -------------------------------------------------------------------------
  // gf(2^4) arithmetic
  // -------------------------------------------------------------------------

  // carry-less product then reduction by the field polynomial
  function automatic data_t gf_mult(data_t a, data_t b);
    logic [2*m-2:0] prod;
    prod = '0;
    for (int i = 0; i < m; i++) begin
      if (b[i]) begin
        prod[i +: m] = prod[i +: m] ^ a;
      end
    end
    // fold the high bits back, top down
    for (int i = 2*m-2; i >= m; i--) begin
      if (prod[i]) begin
        prod[i -: m+1] = prod[i -: m+1] ^ irrpol[m:0];
      end
    end
    return prod[m-1:0];
  endfunction

  // alpha^e, exponent taken mod n so negative powers work too
  function automatic data_t gf_pow(int e);
    data_t p;
    int    r;
    p = data_t'(1);
    r = e % n;
    if (r < 0) begin
      r = r + n;
    end
    for (int j = 0; j < n; j++) begin
      if (j < r) begin
        p = gf_mult(p, data_t'(2));
      end
    end
    return p;
  endfunction

endpackage

// File: hdl/bch_syndrome.sv
`timescale 1ns/1ns

module bch_syndrome (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           enable,
  input  logic           in_val,
  input  bch_pkg::word_t in_word,
  input  bch_pkg::ptr_t  in_ptr,
  output logic           in_rdy,
  input  logic           syn_rdy,
  output logic           syn_val,
  output bch_pkg::data_t syn [1:bch_pkg::t2],
  output bch_pkg::word_t syn_word,
  output bch_pkg::ptr_t  syn_ptr,
  output logic           busy
);

  bch_pkg::data_t syn_next [1:bch_pkg::t2];
  logic           accept;

  // take a new word when the holding stage is free or drains this cycle
  assign in_rdy = enable && (!syn_val || syn_rdy);
  assign accept = in_val && in_rdy;
  assign busy   = syn_val;

  // -------------------------------------------------------------------------
  // s_j = r(alpha^j), all six in one cycle
  // -------------------------------------------------------------------------

  always_comb begin
    for (int j = 1; j <= bch_pkg::t2; j++) begin
      syn_next[j] = '0;
      for (int i = 0; i < bch_pkg::n; i++) begin
        // bit i is the coefficient of x^i
        if (in_word[i]) begin
          syn_next[j] = syn_next[j] ^ bch_pkg::gf_pow(i * j);
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // one-deep holding stage
  // -------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      syn_val <= 1'b0;
    end else if (accept) begin
      syn_val <= 1'b1;
    end else if (syn_rdy) begin
      // berlekamp took it
      syn_val <= 1'b0;
    end
  end

  // syndromes, word and tag wait here for berlekamp
  always_ff @(posedge iclk) begin
    if (accept) begin
      syn      <= syn_next;
      syn_word <= in_word;
      syn_ptr  <= in_ptr;
    end
  end

endmodule

// File: tb/bch_decoder_props.sv
`timescale 1ns/1ns

module bch_decoder_props (
  input logic        iclk,
  input logic        ireset,
  input logic        in_val,
  input logic        in_rdy,
  input logic        syn_busy,
  input logic        ber_busy,
  input logic        out_val,
  input logic        psel,
  input logic        penable,
  input logic        pwrite,
  input logic [3:0]  paddr,
  input logic [31:0] pwdata,
  input logic        pready
);

  // failures so far, polled by the testbench monitor
  int unsigned fail_count = 0;
  logic        idle_accept;
  // ctrl bit0 as last written over apb
  logic        sw_enable;

  // word taken while both the holding stage and berlekamp are empty
  assign idle_accept = in_val && in_rdy && !syn_busy && !ber_busy;

  // completed apb writes to ctrl, seen from the bus side
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      sw_enable <= 1'b0;
    end else if (psel && penable && pready && pwrite && (paddr == bch_pkg::addr_ctrl)) begin
      sw_enable <= pwdata[0];
    end
  end

  // result is a single-cycle pulse
  out_pulse_a: assert property (@(posedge iclk) disable iff (ireset)
    out_val |=> !out_val)
    else begin
      $error("out_val high on two consecutive cycles");
      fail_count++;
    end

  // no acceptance until software sets the enable
  rdy_gated_a: assert property (@(posedge iclk) disable iff (ireset)
    !sw_enable |-> !in_rdy)
    else begin
      $error("in_rdy high while enable is low");
      fail_count++;
    end

  // fixed idle-pipe latency, 24 cycles
  latency_a: assert property (@(posedge iclk) disable iff (ireset)
    $past(idle_accept, 24) |-> out_val)
    else begin
      $error("no out_val 24 cycles after an idle-pipe acceptance");
      fail_count++;
    end

  // zero wait states on apb
  apb_ready_a: assert property (@(posedge iclk) disable iff (ireset)
    (psel && penable) |-> pready)
    else begin
      $error("pready low in an apb access cycle");
      fail_count++;
    end

endmodule

bind bch_decoder bch_decoder_props props_i (.*);

// File: tb/bch_decoder_tb.sv
`timescale 1ns/1ns

module bch_decoder_tb;

  // generator of the (15,5) code, degree 10
  localparam logic [10:0] gen_poly      = 11'h537;
  localparam int          wait_limit    = 100;
  localparam int          drain_limit   = 1000;
  localparam int          stream_period = 23;

  logic           iclk;
  logic           ireset;
  logic           in_val;
  bch_pkg::word_t in_word;
  bch_pkg::ptr_t  in_ptr;
  logic           in_rdy;
  logic           out_val;
  bch_pkg::word_t out_word;
  bch_pkg::ptr_t  out_ptr;
  logic           out_decfail;
  logic [1:0]     out_nerr;
  logic           psel;
  logic           penable;
  logic           pwrite;
  logic [3:0]     paddr;
  logic [31:0]    pwdata;
  logic [31:0]    prdata;
  logic           pready;

  int             seed = 32'haef9_fbe6;
  int             cycle = 0;
  int             corr_tally;
  int             fail_tally;
  logic           saw_stall;
  bch_pkg::ptr_t  next_ptr;
  // scoreboard, one entry per accepted word
  bch_pkg::word_t exp_orig [$];
  bch_pkg::word_t exp_rx [$];
  int             exp_nerr [$];
  bch_pkg::ptr_t  exp_ptr [$];
  int             out_cycles [$];

  bch_decoder bch_decoder_i (.*);

  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;
  end

  always @(posedge iclk) cycle <= cycle + 1;

  // --------------------------------------------------------------------------
  // error exits
  // --------------------------------------------------------------------------

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run aborted");
  endtask

  // --------------------------------------------------------------------------
  // encoder model and error injection
  // --------------------------------------------------------------------------

  // systematic: message in bits 14..10, remainder of msg*x^10 below
  function automatic bch_pkg::word_t encode(input logic [4:0] msg);
    bch_pkg::word_t rem;
    rem = {msg, 10'b0};
    for (int i = 14; i >= 10; i--) begin
      if (rem[i]) begin
        rem = rem ^ (bch_pkg::word_t'(gen_poly) << (i - 10));
      end
    end
    return {msg, rem[9:0]};
  endfunction

  // cnt distinct positions
  task automatic error_mask(input int cnt, output bch_pkg::word_t mask);
    int pos;
    mask = '0;
    while ($countones(mask) < cnt) begin
      pos = $unsigned($random(seed)) % bch_pkg::n;
      mask[pos] = 1'b1;
    end
  endtask

  task automatic make_word(input int nerr, output bch_pkg::word_t orig,
                           output bch_pkg::word_t rx);
    logic [31:0]    raw;
    bch_pkg::word_t mask;
    raw  = $random(seed);
    orig = encode(raw[4:0]);
    error_mask(nerr, mask);
    rx   = orig ^ mask;
  endtask

  // --------------------------------------------------------------------------
  // drivers, called and returning 2 ns after a rising edge
  // --------------------------------------------------------------------------

  // in_val stays high on return so words can stream
  task automatic offer_word(input int nerr);
    bch_pkg::word_t orig;
    bch_pkg::word_t rx;
    int             waited;
    make_word(nerr, orig, rx);
    in_val  = 1'b1;
    in_word = rx;
    in_ptr  = next_ptr;
    waited  = 0;
    @(negedge iclk);
    while (!in_rdy) begin
      saw_stall = 1'b1;
      waited++;
      if (waited > wait_limit) abort_run("timeout: in_rdy never rose for an offered word");
      @(negedge iclk);
    end
    // transfers on the coming edge
    exp_orig.push_back(orig);
    exp_rx.push_back(rx);
    exp_nerr.push_back(nerr);
    exp_ptr.push_back(next_ptr);
    next_ptr = next_ptr + 1'b1;
    @(posedge iclk);
    #2;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    int waited;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge iclk);
    #2;
    penable = 1'b1;
    waited  = 0;
    @(negedge iclk);
    while (!pready) begin
      waited++;
      if (waited > wait_limit) abort_run("timeout: pready stayed low on an apb write");
      @(negedge iclk);
    end
    @(posedge iclk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
    int waited;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge iclk);
    #2;
    penable = 1'b1;
    waited  = 0;
    @(negedge iclk);
    while (!pready) begin
      waited++;
      if (waited > wait_limit) abort_run("timeout: pready stayed low on an apb read");
      @(negedge iclk);
    end
    // registered at the end of setup
    data = prdata;
    @(posedge iclk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // all accepted words delivered
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_ptr.size() != 0) begin
      waited++;
      if (waited > drain_limit) abort_run("timeout: accepted words never came out");
      @(posedge iclk);
    end
    @(posedge iclk);
    #2;
  endtask

  // --------------------------------------------------------------------------
  // output monitor and scoreboard
  // --------------------------------------------------------------------------

  task automatic check_output();
    bch_pkg::word_t orig;
    bch_pkg::word_t rx;
    int             nerr;
    bch_pkg::ptr_t  ptr;
    assert (exp_ptr.size() > 0) else report_mismatch("out_val with no word in flight");
    orig = exp_orig.pop_front();
    rx   = exp_rx.pop_front();
    nerr = exp_nerr.pop_front();
    ptr  = exp_ptr.pop_front();
    out_cycles.push_back(cycle);
    if (out_decfail) fail_tally++;
    else if (out_nerr != 2'd0) corr_tally++;
    assert (out_ptr == ptr)
      else report_mismatch($sformatf("tag %0h, expected %0h", out_ptr, ptr));
    if (nerr <= bch_pkg::t) begin
      assert (!out_decfail)
        else report_mismatch($sformatf("decfail with %0d errors", nerr));
      assert (out_word == orig)
        else report_mismatch($sformatf("word %h, expected %h", out_word, orig));
      assert (out_nerr == nerr)
        else report_mismatch($sformatf("nerr %0d, expected %0d", out_nerr, nerr));
    end else if (out_decfail) begin
      // uncorrectable word leaves untouched
      assert (out_word == rx)
        else report_mismatch($sformatf("failed word %h, received %h", out_word, rx));
    end else begin
      assert (encode(out_word[14:10]) == out_word)
        else report_mismatch($sformatf("miscorrection %h is no codeword", out_word));
      assert ($countones(out_word ^ orig) >= 3)
        else report_mismatch($sformatf("miscorrection %h too close to %h", out_word, orig));
    end
  endtask

  always @(negedge iclk) begin
    if (bch_decoder_i.props_i.fail_count != 0) begin
      abort_run("a bound assertion on the decoder failed");
    end
    if (!ireset && out_val) begin
      check_output();
    end
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  initial begin
    logic [31:0] rd;
    ireset     = 1'b1;
    in_val     = 1'b0;
    in_word    = '0;
    in_ptr     = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    next_ptr   = '0;
    corr_tally = 0;
    fail_tally = 0;
    saw_stall  = 1'b0;
    repeat (5) @(posedge iclk);
    #2;
    ireset = 1'b0;

    // disabled after reset, a waiting word is ignored
    in_val  = 1'b1;
    in_word = encode(5'h15);
    repeat (10) begin
      @(negedge iclk);
      assert (!in_rdy) else report_mismatch("in_rdy high before enable was written");
    end
    @(posedge iclk);
    #2;
    in_val = 1'b0;
    apb_read(bch_pkg::addr_ctrl, rd);
    assert (rd == 32'd0) else report_mismatch($sformatf("ctrl %h after reset", rd));
    apb_write(bch_pkg::addr_ctrl, 32'd1);

    // single words, 0 to 3 errors
    for (int e = 0; e <= bch_pkg::t; e++) begin
      repeat (4) begin
        offer_word(e);
        in_val = 1'b0;
        drain();
      end
    end

    // back to back with in_val held high
    out_cycles.delete();
    saw_stall = 1'b0;
    for (int i = 0; i < 8; i++) offer_word(i % 4);
    in_val = 1'b0;
    drain();
    assert (saw_stall) else report_mismatch("in_rdy never dropped while streaming");
    assert (out_cycles.size() == 8)
      else report_mismatch($sformatf("%0d stream outputs, expected 8", out_cycles.size()));
    for (int i = 1; i < out_cycles.size(); i++) begin
      assert (out_cycles[i] - out_cycles[i-1] == stream_period)
        else report_mismatch($sformatf("outputs %0d cycles apart",
                                       out_cycles[i] - out_cycles[i-1]));
    end

    // beyond the correction limit
    for (int i = 0; i < 12; i++) offer_word(4);
    in_val = 1'b0;
    drain();

    // clearing enable lets the word in flight finish
    offer_word(2);
    in_val = 1'b0;
    apb_read(bch_pkg::addr_status, rd);
    assert (rd == 32'd1) else report_mismatch($sformatf("status %h with a word in flight", rd));
    apb_write(bch_pkg::addr_ctrl, 32'd0);
    drain();
    in_val  = 1'b1;
    in_word = encode(5'h0a);
    repeat (30) begin
      @(negedge iclk);
      assert (!in_rdy) else report_mismatch("in_rdy high after enable was cleared");
    end
    @(posedge iclk);
    #2;
    in_val = 1'b0;
    apb_read(bch_pkg::addr_status, rd);
    assert (rd == 32'd0) else report_mismatch($sformatf("status %h when idle", rd));

    // event counters against the scoreboard tally
    apb_read(bch_pkg::addr_corr_cnt, rd);
    assert (rd == corr_tally)
      else report_mismatch($sformatf("corr_cnt %0d, expected %0d", rd, corr_tally));
    apb_read(bch_pkg::addr_fail_cnt, rd);
    assert (rd == fail_tally)
      else report_mismatch($sformatf("fail_cnt %0d, expected %0d", rd, fail_tally));
    apb_write(bch_pkg::addr_ctrl, 32'd3);
    apb_read(bch_pkg::addr_corr_cnt, rd);
    assert (rd == 32'd0) else report_mismatch($sformatf("corr_cnt %0d after clear", rd));
    apb_read(bch_pkg::addr_fail_cnt, rd);
    assert (rd == 32'd0) else report_mismatch($sformatf("fail_cnt %0d after clear", rd));
    // clear bit is self-resetting
    apb_read(bch_pkg::addr_ctrl, rd);
    assert (rd == 32'd1) else report_mismatch($sformatf("ctrl %h after clear", rd));

    if (bch_decoder_i.props_i.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1, "bound assertions failed");
    end
  end

endmodule
